// File: vlog.f
source/corebus_pkg.sv
source/corebus_request_if.sv
source/corebus_request_fifo.sv
source/corebus_request_router.sv
source/corebus_switch_top.sv
tb/corebus_switch_asserts.sv
tb/tb_corebus_switch.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_corebus_switch
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

SOURCES  := $(shell cat $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_corebus_switch.sv
module tb_corebus_switch;
  localparam int PORTS           = 4;
  localparam int COMMAND_DEPTH   = 2;
  localparam int DATA_DEPTH      = 2;
  localparam int SEL_BITS        = (PORTS > 2) ? $clog2(PORTS) : 1;
  localparam int KIND_READ       = 0;
  localparam int KIND_WRITE      = 1;
  localparam int KIND_BCAST      = 2;
  localparam int KIND_MIXED      = 3;
  localparam int TRANSACTIONS    = 215;   // directed plus 200 mixed
  localparam int MAX_BURST       = 8;
  localparam int WATCHDOG_CYCLES = TRANSACTIONS * MAX_BURST * 20;

  logic                  i_clk;
  logic                  i_rst_n;
  logic                  i_mcmd_valid;
  logic                  o_scmd_accept;
  corebus_pkg::command_t i_mcmd;
  logic                  i_mdata_valid;
  logic                  o_sdata_accept;
  corebus_pkg::data_t    i_mdata;
  logic [PORTS-1:0]      o_mcmd_valid;
  logic [PORTS-1:0]      i_scmd_accept;
  corebus_pkg::command_t o_mcmd;
  logic [PORTS-1:0]      o_mdata_valid;
  logic [PORTS-1:0]      i_sdata_accept;
  corebus_pkg::data_t    o_mdata;

  corebus_pkg::command_t exp_cmd [PORTS][$];
  corebus_pkg::data_t    exp_data [PORTS][$];
  corebus_pkg::command_t write_q [$];   // writes still owing beats

  logic [31:0] cmd_seed;
  logic [31:0] data_seed;
  logic [31:0] port_seed;
  logic        hold_ports;
  logic        random_accepts;
  logic        commands_finished;
  int          cmd_sent;
  int          beat_sent;
  int          mismatch_count;
  int          other_count;

  corebus_switch_top #(
    .PORTS         (PORTS),
    .COMMAND_DEPTH (COMMAND_DEPTH),
    .DATA_DEPTH    (DATA_DEPTH)
  ) UUT (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_mcmd_valid   (i_mcmd_valid),
    .o_scmd_accept  (o_scmd_accept),
    .i_mcmd         (i_mcmd),
    .i_mdata_valid  (i_mdata_valid),
    .o_sdata_accept (o_sdata_accept),
    .i_mdata        (i_mdata),
    .o_mcmd_valid   (o_mcmd_valid),
    .i_scmd_accept  (i_scmd_accept),
    .o_mcmd         (o_mcmd),
    .o_mdata_valid  (o_mdata_valid),
    .i_sdata_accept (i_sdata_accept),
    .o_mdata        (o_mdata)
  );

  bind corebus_switch_top corebus_switch_asserts #(.PORTS(PORTS)) u_asserts (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .o_scmd_accept       (o_scmd_accept),
    .o_sdata_accept      (o_sdata_accept),
    .o_mcmd_valid        (o_mcmd_valid),
    .i_scmd_accept       (i_scmd_accept),
    .o_mcmd              (o_mcmd),
    .o_mdata_valid       (o_mdata_valid),
    .i_sdata_accept      (i_sdata_accept),
    .o_mdata             (o_mdata),
    .i_queue_cmd_valid   (request_if.mcmd_valid),
    .i_queue_cmd_accept  (request_if.scmd_accept),
    .i_queue_cmd         (request_if.mcmd),
    .i_queue_data_valid  (request_if.mdata_valid),
    .i_queue_data_accept (request_if.sdata_accept),
    .i_queue_data        (request_if.mdata)
  );

  always #5 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // reference model: ports a command must reach
  function automatic logic [PORTS-1:0] expected_ports(input corebus_pkg::command_t cmd);
    int sel;
    sel = int'(cmd.address) >> (corebus_pkg::ADDR_WIDTH - SEL_BITS);
    if (cmd.command == corebus_pkg::BCAST_WRITE) begin
      return '1;
    end
    return PORTS'(1) << sel;   // out of range gives no port
  endfunction

  function automatic corebus_pkg::command_t make_command(input int kind, input int port);
    corebus_pkg::command_t cmd;
    logic [31:0]           r;
    int                    k;
    int                    sel;
    cmd_seed = xorshift32(cmd_seed);
    r        = cmd_seed;
    k        = (kind == KIND_MIXED) ? int'(r[31:30]) % 3 : kind;
    sel      = (port < 0) ? int'(r[29:22]) % PORTS : port;
    case (k)
      KIND_READ:  cmd.command = corebus_pkg::READ;
      KIND_WRITE: cmd.command = corebus_pkg::WRITE;
      default:    cmd.command = corebus_pkg::BCAST_WRITE;
    endcase
    cmd.id      = r[3:0];
    cmd.length  = r[6:4];
    cmd.address = {SEL_BITS'(sel), r[corebus_pkg::ADDR_WIDTH-SEL_BITS+6:7]};
    return cmd;
  endfunction

  function automatic int pending_items();
    int n;
    n = 0;
    for (int p = 0; p < PORTS; p++) begin
      n += exp_cmd[p].size() + exp_data[p].size();
    end
    return n;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  //========================================
  // upstream drivers, called on a falling edge
  //========================================
  task automatic send_command(input corebus_pkg::command_t cmd);
    logic [PORTS-1:0] ports;
    ports = expected_ports(cmd);
    for (int p = 0; p < PORTS; p++) begin
      if (ports[p]) exp_cmd[p].push_back(cmd);
    end
    if (cmd.command != corebus_pkg::READ) write_q.push_back(cmd);
    i_mcmd_valid = 1'b1;
    i_mcmd       = cmd;
    while (!o_scmd_accept) @(negedge i_clk);
    @(negedge i_clk);   // taken on the edge just passed
    cmd_sent++;
  endtask

  task automatic send_beat(input corebus_pkg::data_t beat, input logic [PORTS-1:0] ports);
    for (int p = 0; p < PORTS; p++) begin
      if (ports[p]) exp_data[p].push_back(beat);
    end
    i_mdata_valid = 1'b1;
    i_mdata       = beat;
    while (!o_sdata_accept) @(negedge i_clk);
    @(negedge i_clk);
    beat_sent++;
  endtask

  task automatic send_commands(input int count, input int kind, input int port);
    for (int n = 0; n < count; n++) begin
      send_command(make_command(kind, port));
      if (cmd_seed[8]) begin
        i_mcmd_valid = 1'b0;
        repeat (int'(cmd_seed[10:9])) @(negedge i_clk);
      end
    end
    i_mcmd_valid      = 1'b0;
    commands_finished = 1'b1;
  endtask

  task automatic send_bursts();
    corebus_pkg::command_t w;
    corebus_pkg::data_t    beat;
    logic [PORTS-1:0]      ports;
    while (!commands_finished || write_q.size() != 0) begin
      if (write_q.size() == 0) begin
        @(negedge i_clk);
      end else begin
        w     = write_q.pop_front();
        ports = expected_ports(w);
        for (int i = 0; i <= int'(w.length); i++) begin
          data_seed = xorshift32(data_seed);
          beat.data = data_seed;
          beat.last = (i == int'(w.length));   // final beat only
          send_beat(beat, ports);
          if (data_seed[0]) begin
            i_mdata_valid = 1'b0;
            @(negedge i_clk);
          end
        end
        i_mdata_valid = 1'b0;
      end
    end
  endtask

  task automatic run_traffic(input int count, input int kind, input int port);
    commands_finished = 1'b0;
    fork
      send_commands(count, kind, port);
      send_bursts();
    join
  endtask

  task automatic wait_drained();
    while (pending_items() != 0) @(negedge i_clk);
  endtask

  // downstream accepts
  always @(negedge i_clk) begin
    port_seed = xorshift32(port_seed);
    if (hold_ports) begin
      i_scmd_accept  = '0;
      i_sdata_accept = '0;
    end else if (random_accepts) begin
      i_scmd_accept  = port_seed[PORTS-1:0];
      i_sdata_accept = port_seed[2*PORTS-1:PORTS];
    end else begin
      i_scmd_accept  = '1;
      i_sdata_accept = '1;
    end
  end

  //========================================
  // compare process
  //========================================
  always @(posedge i_clk) begin : compare
    corebus_pkg::command_t want_cmd;
    corebus_pkg::data_t    want_data;
    if (i_rst_n) begin
      for (int p = 0; p < PORTS; p++) begin
        if (o_mcmd_valid[p] && i_scmd_accept[p]) begin
          if (exp_cmd[p].size() == 0) begin
            other_count++;
            $display("command arrived on port %0d at %0t with none expected", p, $time);
          end else begin
            want_cmd = exp_cmd[p].pop_front();
            check_value($sformatf("o_mcmd[port %0d]", p), 64'(o_mcmd), 64'(want_cmd));
          end
        end
        if (o_mdata_valid[p] && i_sdata_accept[p]) begin
          if (exp_data[p].size() == 0) begin
            other_count++;
            $display("data beat arrived on port %0d at %0t with none expected", p, $time);
          end else begin
            want_data = exp_data[p].pop_front();
            check_value($sformatf("o_mdata[port %0d]", p), 64'(o_mdata), 64'(want_data));
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("timeout after %0d cycles, traffic did not drain", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin : stimulus
    corebus_pkg::command_t stall_cmd;
    i_clk             = 1'b0;
    i_rst_n           = 1'b0;
    i_mcmd_valid      = 1'b0;
    i_mcmd            = '0;
    i_mdata_valid     = 1'b0;
    i_mdata           = '0;
    i_scmd_accept     = '0;
    i_sdata_accept    = '0;
    cmd_seed          = 32'd24;
    data_seed         = xorshift32(32'd24);
    port_seed         = xorshift32(data_seed);
    hold_ports        = 1'b0;
    random_accepts    = 1'b0;
    commands_finished = 1'b0;
    cmd_sent          = 0;
    beat_sent         = 0;
    mismatch_count    = 0;
    other_count       = 0;

    repeat (5) @(negedge i_clk);
    check_value("o_mcmd_valid", 64'(o_mcmd_valid), 64'(0));
    check_value("o_mdata_valid", 64'(o_mdata_valid), 64'(0));
    check_value("o_scmd_accept", 64'(o_scmd_accept), 64'(0));
    check_value("o_sdata_accept", 64'(o_sdata_accept), 64'(0));
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check_value("o_scmd_accept", 64'(o_scmd_accept), 64'(1));
    check_value("o_sdata_accept", 64'(o_sdata_accept), 64'(1));

    // directed reads and writes, one per port
    for (int k = 0; k < PORTS; k++) run_traffic(1, KIND_READ, k);
    for (int k = 0; k < PORTS; k++) run_traffic(1, KIND_WRITE, k);
    wait_drained();

    random_accepts = 1'b1;
    run_traffic(4, KIND_BCAST, -1);
    run_traffic(200, KIND_MIXED, -1);
    wait_drained();

    //========================================
    // back-pressure with every port stalled
    //========================================
    hold_ports        = 1'b1;
    cmd_sent          = 0;
    beat_sent         = 0;
    commands_finished = 1'b0;
    stall_cmd         = make_command(KIND_WRITE, 1);
    stall_cmd.length  = 3'd3;
    fork
      begin
        send_command(stall_cmd);
        send_command(make_command(KIND_READ, 0));
        send_command(make_command(KIND_READ, 2));
        i_mcmd_valid      = 1'b0;
        commands_finished = 1'b1;
      end
      send_bursts();
      begin
        repeat (20) @(negedge i_clk);
        check_value("o_scmd_accept count", 64'(cmd_sent), 64'(COMMAND_DEPTH));
        check_value("o_sdata_accept count", 64'(beat_sent), 64'(DATA_DEPTH));
        check_value("o_scmd_accept", 64'(o_scmd_accept), 64'(0));
        check_value("o_sdata_accept", 64'(o_sdata_accept), 64'(0));
        hold_ports = 1'b0;
      end
    join
    wait_drained();

    repeat (5) @(negedge i_clk);
    check_value("o_mcmd_valid", 64'(o_mcmd_valid), 64'(0));
    check_value("o_mdata_valid", 64'(o_mdata_valid), 64'(0));

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb/corebus_switch_asserts.sv
module corebus_switch_asserts #(
  parameter int PORTS = 4
)(
  input logic                  i_clk,
  input logic                  i_rst_n,
  input logic                  o_scmd_accept,
  input logic                  o_sdata_accept,
  input logic [PORTS-1:0]      o_mcmd_valid,
  input logic [PORTS-1:0]      i_scmd_accept,
  input corebus_pkg::command_t o_mcmd,
  input logic [PORTS-1:0]      o_mdata_valid,
  input logic [PORTS-1:0]      i_sdata_accept,
  input corebus_pkg::data_t    o_mdata,
  // queue heads as seen by the route stage
  input logic                  i_queue_cmd_valid,
  input logic                  i_queue_cmd_accept,
  input corebus_pkg::command_t i_queue_cmd,
  input logic                  i_queue_data_valid,
  input logic                  i_queue_data_accept,
  input corebus_pkg::data_t    i_queue_data
);

  logic write_open;   // write removed, last beat not yet gone

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      write_open <= 1'b0;
    end else if (i_queue_cmd_valid && i_queue_cmd_accept &&
                 i_queue_cmd.command inside {corebus_pkg::WRITE, corebus_pkg::BCAST_WRITE}) begin
      write_open <= 1'b1;
    end else if (i_queue_data_valid && i_queue_data_accept && i_queue_data.last) begin
      write_open <= 1'b0;
    end
  end

  // quiet outputs while reset is held
  a_reset_quiet : assert property (@(posedge i_clk)
    !i_rst_n |-> (o_mcmd_valid == '0 && o_mdata_valid == '0 &&
                  !o_scmd_accept && !o_sdata_accept))
    else $error("valid or accept high during reset");

  a_data_needs_write : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_mdata_valid != '0) |-> write_open)
    else $error("data valid without a pending write burst");

  //========================================
  // per-port handshake stability
  //========================================
  for (genvar p = 0; p < PORTS; p++) begin : g_port
    a_cmd_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_mcmd_valid[p] && !i_scmd_accept[p]) |=> (o_mcmd_valid[p] && $stable(o_mcmd)))
      else $error("command valid dropped or payload changed before accept");

    a_data_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_mdata_valid[p] && !i_sdata_accept[p]) |=> (o_mdata_valid[p] && $stable(o_mdata)))
      else $error("data valid dropped or payload changed before accept");
  end

endmodule

// File: source/corebus_switch_top.sv
module corebus_switch_top #(
  parameter int PORTS         = 4,
  parameter int COMMAND_DEPTH = 2,
  parameter int DATA_DEPTH    = 2
)(
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  // upstream command
  input  var logic                  i_mcmd_valid,
  output var logic                  o_scmd_accept,
  input  var corebus_pkg::command_t i_mcmd,
  // upstream data
  input  var logic                  i_mdata_valid,
  output var logic                  o_sdata_accept,
  input  var corebus_pkg::data_t    i_mdata,
  // downstream command
  output var logic [PORTS-1:0]      o_mcmd_valid,
  input  var logic [PORTS-1:0]      i_scmd_accept,
  output var corebus_pkg::command_t o_mcmd,
  // downstream data
  output var logic [PORTS-1:0]      o_mdata_valid,
  input  var logic [PORTS-1:0]      i_sdata_accept,
  output var corebus_pkg::data_t    o_mdata
);
  corebus_request_if request_if();

  //========================================
  // upstream queues
  //========================================
  corebus_request_fifo #(
    .payload_t (corebus_pkg::command_t),
    .DEPTH     (COMMAND_DEPTH)
  ) u_command_fifo (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_valid   (i_mcmd_valid),
    .o_accept  (o_scmd_accept),
    .i_payload (i_mcmd),
    .o_valid   (request_if.mcmd_valid),
    .i_accept  (request_if.scmd_accept),
    .o_payload (request_if.mcmd)
  );

  corebus_request_fifo #(
    .payload_t (corebus_pkg::data_t),
    .DEPTH     (DATA_DEPTH)
  ) u_data_fifo (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_valid   (i_mdata_valid),
    .o_accept  (o_sdata_accept),
    .i_payload (i_mdata),
    .o_valid   (request_if.mdata_valid),
    .i_accept  (request_if.sdata_accept),
    .o_payload (request_if.mdata)
  );

  //========================================
  // route stage
  //========================================
  corebus_request_router #(
    .PORTS (PORTS)
  ) u_router (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .up_if          (request_if.sink),
    .o_mcmd_valid   (o_mcmd_valid),
    .i_scmd_accept  (i_scmd_accept),
    .o_mcmd         (o_mcmd),
    .o_mdata_valid  (o_mdata_valid),
    .i_sdata_accept (i_sdata_accept),
    .o_mdata        (o_mdata)
  );
endmodule

// File: source/corebus_request_router.sv
module corebus_request_router #(
  parameter int PORTS = 4
)(
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  corebus_request_if.sink           up_if,
  // downstream command
  output var logic [PORTS-1:0]      o_mcmd_valid,
  input  var logic [PORTS-1:0]      i_scmd_accept,
  output var corebus_pkg::command_t o_mcmd,
  // downstream data
  output var logic [PORTS-1:0]      o_mdata_valid,
  input  var logic [PORTS-1:0]      i_sdata_accept,
  output var corebus_pkg::data_t    o_mdata
);
  localparam int SELECT_WIDTH = corebus_pkg::select_width(PORTS);
  localparam int SELECT_LSB   = corebus_pkg::ADDR_WIDTH - SELECT_WIDTH;

  logic [SELECT_WIDTH-1:0] select;
  logic                    is_bcast;
  logic                    is_write;
  logic [PORTS-1:0]        command_mask;
  logic [PORTS-1:0]        command_done;
  logic [PORTS-1:0]        command_take;
  logic                    command_offer;
  logic                    command_pop;

  logic                    burst_pending;
  logic [PORTS-1:0]        data_mask;
  logic [PORTS-1:0]        data_done;
  logic [PORTS-1:0]        data_take;
  logic                    data_offer;
  logic                    data_pop;

  // same head item goes to every port
  always_comb begin
    o_mcmd  = up_if.mcmd;
    o_mdata = up_if.mdata;
  end

  //========================================
  // command routing
  //========================================
  always_comb begin
    select   = up_if.mcmd.address[SELECT_LSB+:SELECT_WIDTH];
    is_bcast = up_if.mcmd.command == corebus_pkg::BCAST_WRITE;
    is_write = up_if.mcmd.command inside {corebus_pkg::WRITE, corebus_pkg::BCAST_WRITE};
    for (int i = 0; i < PORTS; i++) begin
      command_mask[i] = is_bcast || (select == SELECT_WIDTH'(i));
    end
  end

  // held back while a write burst is still open
  always_comb begin
    command_offer = up_if.mcmd_valid && !burst_pending;
    o_mcmd_valid  = {PORTS{command_offer}} & command_mask & ~command_done;
    command_take  = o_mcmd_valid & i_scmd_accept;
    // an unmapped select has an empty mask and is dropped
    command_pop   = command_offer &&
                    (((command_done | command_take) & command_mask) == command_mask);
    up_if.scmd_accept = command_pop;
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      command_done <= '0;
    end else if (command_pop) begin
      command_done <= '0;
    end else begin
      command_done <= command_done | command_take;
    end
  end

  //========================================
  // write burst tracking
  //========================================
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      burst_pending <= 1'b0;
      data_mask     <= '0;
    end else if (command_pop && is_write) begin
      burst_pending <= 1'b1;
      data_mask     <= command_mask;
    end else if (data_pop && up_if.mdata.last) begin
      burst_pending <= 1'b0;
    end
  end

  always_comb begin
    data_offer    = up_if.mdata_valid && burst_pending;
    o_mdata_valid = {PORTS{data_offer}} & data_mask & ~data_done;
    data_take     = o_mdata_valid & i_sdata_accept;
    data_pop      = data_offer &&
                    (((data_done | data_take) & data_mask) == data_mask);
    up_if.sdata_accept = data_pop;
  end

  // per-port done flags for the current beat
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      data_done <= '0;
    end else if (data_pop) begin
      data_done <= '0;
    end else begin
      data_done <= data_done | data_take;
    end
  end
endmodule

// File: source/corebus_request_fifo.sv
module corebus_request_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
)(
  input  var logic     i_clk,
  input  var logic     i_rst_n,
  // write side
  input  var logic     i_valid,
  output var logic     o_accept,
  input  var payload_t i_payload,
  // read side
  output var logic     o_valid,
  input  var logic     i_accept,
  output var payload_t o_payload
);
  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  payload_t               mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic [COUNT_WIDTH-1:0] count_next;
  logic                   push;
  logic                   pop;

  always_comb begin
    push      = i_valid && o_accept;
    pop       = o_valid && i_accept;
    o_valid   = count != '0;
    o_payload = mem[rd_ptr];   // no bypass
  end

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + COUNT_WIDTH'(1);
    end else if (pop && !push) begin
      count_next = count - COUNT_WIDTH'(1);
    end
  end

  // ring pointers, wrap at DEPTH
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + PTR_WIDTH'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + PTR_WIDTH'(1);
      end
      count <= count_next;
    end
  end

  // accept follows the fill count only, low through reset
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_accept <= 1'b0;
    end else begin
      o_accept <= count_next != COUNT_WIDTH'(DEPTH);
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_payload;
    end
  end
endmodule

// File: source/corebus_request_if.sv
interface corebus_request_if;
  logic                 mcmd_valid;
  logic                 scmd_accept;
  corebus_pkg::command_t mcmd;
  logic                 mdata_valid;
  logic                 sdata_accept;
  corebus_pkg::data_t    mdata;

  modport command_source (
    output mcmd_valid, mcmd,
    input  scmd_accept
  );

  modport data_source (
    output mdata_valid, mdata,
    input  sdata_accept
  );

  // route stage side
  modport sink (
    input  mcmd_valid, mcmd, mdata_valid, mdata,
    output scmd_accept, sdata_accept
  );

  modport monitor (
    input mcmd_valid, scmd_accept, mcmd,
    input mdata_valid, sdata_accept, mdata
  );
endinterface

// File: source/corebus_pkg.sv
package corebus_pkg;

  //========================================
  // field widths
  //========================================
  localparam int ID_WIDTH     = 4;
  localparam int ADDR_WIDTH   = 16;
  localparam int LENGTH_WIDTH = 3;   // beats minus one
  localparam int DATA_WIDTH   = 32;

  //========================================
  // command codes
  //========================================
  typedef enum logic [1:0] {
    READ        = 2'd0,
    WRITE       = 2'd1,
    BCAST_WRITE = 2'd2   // posted, goes to all ports
  } command_type;

  //========================================
  // payloads
  //========================================
  // command channel, 25 bits
  typedef struct packed {
    command_type             command;
    logic [ID_WIDTH-1:0]     id;
    logic [ADDR_WIDTH-1:0]   address;  // top bits name the port
    logic [LENGTH_WIDTH-1:0] length;
  } command_t;

  // data channel, 33 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;   // final beat of a burst
  } data_t;

  // address bits needed to name one of the ports
  function automatic int select_width(int ports);
    int width;
    width = $clog2(ports);
    return (width < 1) ? 1 : width;
  endfunction

endpackage
